// ==== src/lsu_pkg.sv ====
// ----------------------------------------
// shared types for the load/store unit, RV32 only
// struct widths assume up to 16 banks of up to 64k words
// ----------------------------------------
`default_nettype none

package lsu_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  parameter int XLEN          = 32;
  parameter int TRANS_ID_BITS = 3;
  parameter int WORD_IDX_BITS = 16;
  parameter int BANK_SEL_BITS = 4;

  typedef logic [XLEN-1:0]          xlen_t;
  typedef logic [XLEN/8-1:0]        be_t;
  typedef logic [1:0]               byte_off_t;
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
  typedef logic [3:0]               lsu_op_t;
  typedef logic [3:0]               cause_t;

  // ----------------------------------------
  // operation codes
  // ----------------------------------------
  // bit 3 store, bit 2 unsigned load, bits 1:0 size
  parameter int OP_STORE_BIT    = 3;
  parameter int OP_UNSIGNED_BIT = 2;

  parameter logic [1:0] SIZE_B = 2'b00;
  parameter logic [1:0] SIZE_H = 2'b01;
  parameter logic [1:0] SIZE_W = 2'b10;

  parameter lsu_op_t OP_LB  = 4'b0000;
  parameter lsu_op_t OP_LH  = 4'b0001;
  parameter lsu_op_t OP_LW  = 4'b0010;
  parameter lsu_op_t OP_LBU = 4'b0100;
  parameter lsu_op_t OP_LHU = 4'b0101;
  parameter lsu_op_t OP_SB  = 4'b1000;
  parameter lsu_op_t OP_SH  = 4'b1001;
  parameter lsu_op_t OP_SW  = 4'b1010;

  // RISC-V mcause values
  parameter cause_t CAUSE_LD_MISALIGNED   = 4'd4;
  parameter cause_t CAUSE_LD_ACCESS_FAULT = 4'd5;
  parameter cause_t CAUSE_ST_MISALIGNED   = 4'd6;
  parameter cause_t CAUSE_ST_ACCESS_FAULT = 4'd7;

  // ----------------------------------------
  // structs
  // ----------------------------------------
  typedef struct packed {
    logic   valid;
    cause_t cause;
    xlen_t  tval;
  } exception_t;

  typedef struct packed {
    logic        valid;
    lsu_op_t     op;
    xlen_t       operand_a;
    logic [11:0] imm;
    xlen_t       store_data;
    trans_id_t   trans_id;
  } lsu_req_t;

  // same layout on the load and the store port
  typedef struct packed {
    logic       valid;
    trans_id_t  trans_id;
    xlen_t      result;
    exception_t exception;
  } lsu_resp_t;

  typedef struct packed {
    logic                     valid;
    logic                     we;
    logic [WORD_IDX_BITS-1:0] word_idx;
    be_t                      be;
    xlen_t                    wdata;
  } bank_req_t;

  // travels beside the bank access to the aligner
  typedef struct packed {
    logic                     valid;
    logic                     is_store;
    lsu_op_t                  op;
    trans_id_t                trans_id;
    byte_off_t                byte_off;
    logic [BANK_SEL_BITS-1:0] bank_sel;
    exception_t               exception;
  } access_meta_t;

endpackage

`default_nettype wire

// ==== src/lsu_agu.sv ====
// ----------------------------------------
// address unit, one request per cycle, no back-pressure
// NUM_BANKS and BANK_WORDS must be powers of two
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_agu #(
  parameter int unsigned NUM_BANKS  = 4,
  parameter int unsigned BANK_WORDS = 64
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  lsu_pkg::lsu_req_t     req_i,
  output lsu_pkg::bank_req_t    bank_req_o,
  output logic [NUM_BANKS-1:0]  bank_en_o,
  output lsu_pkg::access_meta_t meta_o
);
  import lsu_pkg::*;

  localparam int unsigned BANK_BITS = $clog2(NUM_BANKS);
  localparam int unsigned MEM_BYTES = NUM_BANKS * BANK_WORDS * 4;

  xlen_t                    ea;
  logic [1:0]               size;
  logic                     is_store;
  byte_off_t                off;
  be_t                      be;
  logic                     misaligned;
  logic                     out_of_range;
  exception_t               exc;
  logic [BANK_SEL_BITS-1:0] bank_sel;
  logic [WORD_IDX_BITS-1:0] word_idx;
  logic [NUM_BANKS-1:0]     bank_en_d;
  bank_req_t                bank_req_d;
  access_meta_t             meta_d;

  // ----------------------------------------
  // effective address
  // ----------------------------------------
  assign ea       = req_i.operand_a + {{(XLEN-12){req_i.imm[11]}}, req_i.imm};
  assign size     = req_i.op[1:0];
  assign is_store = req_i.op[OP_STORE_BIT];
  assign off      = ea[1:0];

  // word interleaving: bank from the bits right above the byte offset
  assign bank_sel = BANK_SEL_BITS'((ea >> 2) & xlen_t'(NUM_BANKS - 1));
  assign word_idx = WORD_IDX_BITS'(ea >> (2 + BANK_BITS));

  always_comb begin
    case (size)
      SIZE_B:  be = be_t'(4'b0001 << off);
      SIZE_H:  be = be_t'(4'b0011 << off);
      default: be = 4'b1111;
    endcase
  end

  // ----------------------------------------
  // exception detection
  // ----------------------------------------
  assign misaligned   = ((size == SIZE_H) && off[0]) ||
                        ((size != SIZE_B) && (size != SIZE_H) && (off != 2'b00));
  assign out_of_range = (ea >= xlen_t'(MEM_BYTES));

  always_comb begin
    exc = '0;
    if (req_i.valid && (out_of_range || misaligned)) begin
      exc.valid = 1'b1;
      exc.tval  = ea;
      // access fault wins over misalignment
      if (out_of_range) begin
        exc.cause = is_store ? CAUSE_ST_ACCESS_FAULT : CAUSE_LD_ACCESS_FAULT;
      end else begin
        exc.cause = is_store ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
      end
    end
  end

  // ----------------------------------------
  // bank request and metadata
  // ----------------------------------------
  always_comb begin
    bank_req_d.valid    = req_i.valid && !exc.valid;
    bank_req_d.we       = is_store;
    bank_req_d.word_idx = word_idx;
    bank_req_d.be       = be;
    // store data moved into its byte lanes
    bank_req_d.wdata    = req_i.store_data << {off, 3'b000};
  end

  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      bank_en_d[b] = bank_req_d.valid && (int'(bank_sel) == b);
    end
  end

  always_comb begin
    meta_d.valid     = req_i.valid;
    meta_d.is_store  = is_store;
    meta_d.op        = req_i.op;
    meta_d.trans_id  = req_i.trans_id;
    meta_d.byte_off  = off;
    meta_d.bank_sel  = bank_sel;
    meta_d.exception = exc;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_req_o <= '0;
      bank_en_o  <= '0;
      meta_o     <= '0;
    end else begin
      bank_req_o <= bank_req_d;
      bank_en_o  <= bank_en_d;
      meta_o     <= meta_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/data_bank.sv ====
// ----------------------------------------
// one scratchpad bank, BANK_WORDS a power of two, at least 2
// contents are undefined after reset
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module data_bank #(
  parameter int unsigned BANK_WORDS = 64
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               en_i,
  input  lsu_pkg::bank_req_t req_i,
  output lsu_pkg::xlen_t     rdata_o
);
  import lsu_pkg::*;

  localparam int unsigned IDX_BITS = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

  xlen_t               mem [BANK_WORDS];
  logic [IDX_BITS-1:0] idx;
  logic                access;

  assign idx    = req_i.word_idx[IDX_BITS-1:0];
  assign access = en_i && req_i.valid;

  // byte-lane write
  always_ff @(posedge clk_i) begin
    if (access && req_i.we) begin
      for (int i = 0; i < XLEN/8; i++) begin
        if (req_i.be[i]) begin
          mem[idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // registered read, holds between loads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (access && !req_i.we) begin
      rdata_o <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// ==== src/load_align.sv ====
// ----------------------------------------
// load data alignment and response registers
// expects bank read data one cycle after the metadata
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module load_align #(
  parameter int unsigned NUM_BANKS = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  lsu_pkg::access_meta_t                meta_i,
  input  lsu_pkg::xlen_t       [NUM_BANKS-1:0] bank_rdata_i,
  output lsu_pkg::lsu_resp_t                   load_resp_o,
  output lsu_pkg::lsu_resp_t                   store_resp_o
);
  import lsu_pkg::*;

  access_meta_t meta_q;
  xlen_t        bank_word;
  xlen_t        shifted;
  xlen_t        load_data;
  logic         is_unsigned;
  lsu_resp_t    load_resp_d;
  lsu_resp_t    store_resp_d;

  // ----------------------------------------
  // line up metadata with the bank read
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_q <= '0;
    end else begin
      meta_q <= meta_i;
    end
  end

  // ----------------------------------------
  // select, shift, extend
  // ----------------------------------------
  always_comb begin
    bank_word = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (int'(meta_q.bank_sel) == b) begin
        bank_word = bank_rdata_i[b];
      end
    end
  end

  assign shifted     = bank_word >> {meta_q.byte_off, 3'b000};
  assign is_unsigned = meta_q.op[OP_UNSIGNED_BIT];

  always_comb begin
    case (meta_q.op[1:0])
      SIZE_B: begin
        load_data = is_unsigned ? {24'b0, shifted[7:0]}
                                : {{24{shifted[7]}}, shifted[7:0]};
      end
      SIZE_H: begin
        load_data = is_unsigned ? {16'b0, shifted[15:0]}
                                : {{16{shifted[15]}}, shifted[15:0]};
      end
      default: begin
        load_data = shifted;
      end
    endcase
  end

  // ----------------------------------------
  // responses
  // ----------------------------------------
  always_comb begin
    load_resp_d.valid     = meta_q.valid && !meta_q.is_store;
    load_resp_d.trans_id  = meta_q.trans_id;
    // faulting loads never read a bank
    load_resp_d.result    = meta_q.exception.valid ? '0 : load_data;
    load_resp_d.exception = meta_q.exception;

    store_resp_d.valid     = meta_q.valid && meta_q.is_store;
    store_resp_d.trans_id  = meta_q.trans_id;
    store_resp_d.result    = '0;
    store_resp_d.exception = meta_q.exception;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_resp_o  <= '0;
      store_resp_o <= '0;
    end else begin
      load_resp_o  <= load_resp_d;
      store_resp_o <= store_resp_d;
    end
  end

endmodule

`default_nettype wire

// ==== src/lsu_top.sv ====
// ----------------------------------------
// load/store unit with banked scratchpad, fixed 3-cycle latency
// NUM_BANKS 1..16, BANK_WORDS 2..65536, both powers of two
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
  parameter int unsigned NUM_BANKS  = 4,
  parameter int unsigned BANK_WORDS = 64
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  lsu_pkg::lsu_req_t  lsu_req_i,
  output lsu_pkg::lsu_resp_t load_resp_o,
  output lsu_pkg::lsu_resp_t store_resp_o
);
  import lsu_pkg::*;

  bank_req_t                  bank_req;
  logic       [NUM_BANKS-1:0] bank_en;
  access_meta_t               meta;
  xlen_t      [NUM_BANKS-1:0] bank_rdata;

  // ----------------------------------------
  // address generation
  // ----------------------------------------
  lsu_agu #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_WORDS (BANK_WORDS)
  ) u_lsu_agu (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (lsu_req_i),
    .bank_req_o (bank_req),
    .bank_en_o  (bank_en),
    .meta_o     (meta)
  );

  // ----------------------------------------
  // word-interleaved banks
  // ----------------------------------------
  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    data_bank #(
      .BANK_WORDS (BANK_WORDS)
    ) u_data_bank (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .en_i    (bank_en[b]),
      .req_i   (bank_req),
      .rdata_o (bank_rdata[b])
    );
  end

  // ----------------------------------------
  // return path
  // ----------------------------------------
  load_align #(
    .NUM_BANKS (NUM_BANKS)
  ) u_load_align (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .meta_i       (meta),
    .bank_rdata_i (bank_rdata),
    .load_resp_o  (load_resp_o),
    .store_resp_o (store_resp_o)
  );

endmodule

`default_nettype wire

// ==== dv/tb_lsu_top.sv ====
// ----------------------------------------
// testbench for lsu_top at 4 banks of 64 words
// memory is filled by word stores before any load
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;
  import lsu_pkg::*;

  localparam int unsigned NUM_BANKS  = 4;
  localparam int unsigned BANK_WORDS = 64;
  localparam int unsigned MEM_BYTES  = NUM_BANKS * BANK_WORDS * 4;
  localparam int unsigned ADDR_BITS  = $clog2(MEM_BYTES);

  typedef struct packed {
    logic        is_store;
    logic [31:0] due;
    lsu_resp_t   resp;
  } expect_t;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  lsu_req_t    lsu_req = '0;
  lsu_resp_t   load_resp;
  lsu_resp_t   store_resp;
  logic [7:0]  ref_mem [MEM_BYTES];
  expect_t     exp_q[$];
  logic [31:0] cycle = '0;
  logic [31:0] rng = 32'hcd5f886c;
  trans_id_t   next_tid = '0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  logic        timed_out = 1'b0;

  lsu_top #(
    .NUM_BANKS  (NUM_BANKS),
    .BANK_WORDS (BANK_WORDS)
  ) u_lsu_top (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .lsu_req_i    (lsu_req),
    .load_resp_o  (load_resp),
    .store_resp_o (store_resp)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // responses are sampled on the falling edge
  always @(negedge clk) check_responses();

  task automatic report_fail(input string msg);
    $display("Fail %0t %s", $time, msg);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic xlen_t fill_word(input xlen_t a);
    return {~a[15:0], a[15:0]} ^ (a << 7);
  endfunction

  function automatic xlen_t extend(input xlen_t w, input lsu_op_t op);
    logic sgn;
    sgn = !op[2];
    case (op[1:0])
      2'd0:    return {{24{sgn & w[7]}}, w[7:0]};
      2'd1:    return {{16{sgn & w[15]}}, w[15:0]};
      default: return w;
    endcase
  endfunction

  // drives one request and queues the response the access rules predict
  task automatic issue(input lsu_op_t op, input xlen_t opa, input logic [11:0] imm,
                       input xlen_t data);
    expect_t              e;
    xlen_t                ea;
    xlen_t                word;
    logic [ADDR_BITS-1:0] a;
    logic                 bad_align;
    logic                 bad_range;
    int                   nb;
    @(posedge clk);
    #1;
    lsu_req = '{valid: 1'b1, op: op, operand_a: opa, imm: imm, store_data: data,
                trans_id: next_tid};
    ea        = opa + {{20{imm[11]}}, imm};
    nb        = 1 << op[1:0];
    bad_align = (op[1:0] == 2'd1 && ea[0]) || (op[1:0] == 2'd2 && ea[1:0] != 2'b00);
    bad_range = ea >= MEM_BYTES;
    e = '0;
    e.is_store      = op[3];
    e.due           = cycle + 3;
    e.resp.valid    = 1'b1;
    e.resp.trans_id = next_tid;
    if (bad_range || bad_align) begin
      e.resp.exception.valid = 1'b1;
      e.resp.exception.tval  = ea;
      if (bad_range) begin
        e.resp.exception.cause = op[3] ? CAUSE_ST_ACCESS_FAULT : CAUSE_LD_ACCESS_FAULT;
      end else begin
        e.resp.exception.cause = op[3] ? CAUSE_ST_MISALIGNED : CAUSE_LD_MISALIGNED;
      end
    end else begin
      word = '0;
      for (int i = 0; i < nb; i++) begin
        a = ea[ADDR_BITS-1:0] + ADDR_BITS'(i);
        if (op[3]) ref_mem[a] = data[8*i +: 8];
        else word[8*i +: 8] = ref_mem[a];
      end
      if (!op[3]) e.resp.result = extend(word, op);
    end
    exp_q.push_back(e);
    next_tid++;
  endtask

  task automatic check_responses();
    expect_t   head;
    lsu_resp_t got;
    if (load_resp.valid || store_resp.valid) begin
      if (exp_q.size() == 0) begin
        report_problem("response strobe with no request in flight");
      end else begin
        head = exp_q.pop_front();
        got  = head.is_store ? store_resp : load_resp;
        checks++;
        assert (got.valid && !(load_resp.valid && store_resp.valid))
          else report_fail($sformatf("id %0d on the wrong port", head.resp.trans_id));
        assert (cycle == head.due)
          else report_fail($sformatf("id %0d at cycle %0d, due %0d", head.resp.trans_id,
                                     cycle, head.due));
        assert (got == head.resp)
          else report_fail($sformatf("id %0d got %h exc %b/%0d/%h, exp id %0d %h exc %b/%0d/%h",
                                     got.trans_id, got.result, got.exception.valid,
                                     got.exception.cause, got.exception.tval,
                                     head.resp.trans_id, head.resp.result,
                                     head.resp.exception.valid, head.resp.exception.cause,
                                     head.resp.exception.tval));
      end
    end
    if (exp_q.size() != 0) begin
      head = exp_q[0];
      if (head.due < cycle) begin
        report_problem($sformatf("no response arrived for id %0d", head.resp.trans_id));
        void'(exp_q.pop_front());
      end
    end
  endtask

  // idle the bus and wait until every response is back
  task automatic drain();
    int waited;
    @(posedge clk);
    #1;
    lsu_req = '0;
    waited  = 0;
    while (exp_q.size() != 0 && waited < 10) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      report_problem($sformatf("timeout, %0d responses still outstanding", exp_q.size()));
      timed_out = 1'b1;
      exp_q.delete();
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("test %s: %0d errors", name, errors - err_before);
  endtask

  function automatic lsu_op_t pick_op(input logic [2:0] k);
    case (k)
      3'd0:    return OP_LB;
      3'd1:    return OP_LBU;
      3'd2:    return OP_LH;
      3'd3:    return OP_LHU;
      3'd4:    return OP_LW;
      3'd5:    return OP_SB;
      3'd6:    return OP_SH;
      default: return OP_SW;
    endcase
  endfunction

  initial begin
    int          e0;
    xlen_t       addr;
    lsu_op_t     op;
    byte_off_t   off;
    logic [7:0]  widx;
    logic [11:0] imm;
    // ----------------------------------------
    // reset and fill
    // ----------------------------------------
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      assert (!load_resp.valid && !store_resp.valid)
        else report_fail("response valid during reset");
    end
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) begin
      @(negedge clk);
      assert (!load_resp.valid && !store_resp.valid)
        else report_fail("response valid after reset with no request");
    end
    end_test("reset", e0);
    e0 = errors;
    for (int w = 0; w < int'(MEM_BYTES / 4); w++) begin
      addr = xlen_t'(w) << 2;
      issue(OP_SW, addr, 12'h000, fill_word(addr));
    end
    drain();
    end_test("fill", e0);
    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    e0 = errors;
    issue(OP_SW, 32'h40, 12'h000, 32'hdeadbeef);
    issue(OP_LW, 32'h40, 12'h000, '0);
    issue(OP_SW, 32'h100, 12'hffc, 32'h12345678);
    issue(OP_LW, 32'hf0, 12'h00c, '0);
    drain();
    end_test("word_rw", e0);
    e0 = errors;
    issue(OP_SB, 32'h81, 12'h000, 32'h000000a5);
    issue(OP_SB, 32'h83, 12'h000, 32'hffffff7f);
    issue(OP_SH, 32'h86, 12'h000, 32'h00008001);
    issue(OP_SH, 32'h88, 12'h000, 32'h00007ffe);
    for (int i = 0; i < 4; i++) begin
      issue(OP_LB, 32'h80 + xlen_t'(i), 12'h000, '0);
      issue(OP_LBU, 32'h80 + xlen_t'(i), 12'h000, '0);
    end
    for (int i = 0; i < 4; i += 2) begin
      issue(OP_LH, 32'h84 + xlen_t'(i), 12'h000, '0);
      issue(OP_LHU, 32'h88 + xlen_t'(i), 12'h000, '0);
    end
    issue(OP_LW, 32'h80, 12'h000, '0);
    issue(OP_LW, 32'h84, 12'h000, '0);
    drain();
    end_test("sub_word", e0);
    e0 = errors;
    issue(OP_LH, 32'h21, 12'h000, '0);
    issue(OP_SH, 32'h23, 12'h000, 32'hffffffff);
    issue(OP_LW, 32'h22, 12'h000, '0);
    issue(OP_LW, 32'h1d, 12'h004, '0);
    issue(OP_SW, 32'h23, 12'h000, 32'hffffffff);
    issue(OP_SW, 32'h26, 12'h000, 32'hffffffff);
    issue(OP_LW, 32'h20, 12'h000, '0);
    issue(OP_LW, 32'h24, 12'h000, '0);
    drain();
    end_test("misaligned", e0);
    e0 = errors;
    issue(OP_LW, 32'h400, 12'h000, '0);
    issue(OP_SW, 32'h3fc, 12'h004, 32'h55aa55aa);
    issue(OP_LH, 32'h401, 12'h000, '0);
    issue(OP_SW, 32'h1003, 12'h000, 32'h55aa55aa);
    issue(OP_LB, 32'h0, 12'hffc, '0);
    issue(OP_SB, 32'h400, 12'h000, 32'h000000ff);
    issue(OP_LW, 32'h3fc, 12'h000, '0);
    // out-of-range stores would wrap onto word 0
    issue(OP_LW, 32'h0, 12'h000, '0);
    drain();
    end_test("access_fault", e0);
    // ----------------------------------------
    // random back-to-back traffic
    // ----------------------------------------
    e0   = errors;
    widx = '0;
    for (int n = 0; n < 200; n++) begin
      rng = xorshift(rng);
      op  = pick_op(rng[2:0]);
      // a quarter of the accesses reuse the previous word
      if (rng[5:4] != 2'b00) widx = rng[13:6];
      case (op[1:0])
        2'd0:    off = rng[15:14];
        2'd1:    off = {rng[15], 1'b0};
        default: off = 2'b00;
      endcase
      addr = {22'b0, widx, off};
      imm  = rng[27:16];
      rng  = xorshift(rng);
      issue(op, addr - {{20{imm[11]}}, imm}, imm, rng);
    end
    drain();
    end_test("random", e0);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
src/lsu_pkg.sv
src/lsu_agu.sv
src/data_bank.sv
src/load_align.sv
src/lsu_top.sv
dv/tb_lsu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_lsu_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
